// ==== rv_pkg.sv ====
package rv_pkg;

  // register width
  localparam int XLEN   = 64;
  // instruction width
  localparam int ILEN   = 32;
  // register address width, 32 registers
  localparam int REG_AW = 5;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // alu operations seen by the execute unit
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    // signed compare, result is 0 or 1
    ALU_SLT,
    // operand b straight through, used by lui
    ALU_PASSB
  } alu_op_e;

  // what decode hands to the execute unit
  typedef struct packed {
    alu_op_e           alu_op;
    // rs1 data
    logic [XLEN-1:0]   a;
    // rs2 data or immediate
    logic [XLEN-1:0]   b;
    logic [REG_AW-1:0] rd;
    // low for x0 targets and unsupported encodings
    logic              wen;
  } issue_req_t;

endpackage

// ==== pipe_ifs.sv ====
`timescale 1ns/1ps

// if/id register to decode
interface fetch_if;
  import rv_pkg::*;

  logic            valid;
  logic            ready;
  logic [XLEN-1:0] pc;
  logic [ILEN-1:0] inst;

  modport src (output valid, pc, inst, input ready);
  modport dst (input valid, pc, inst, output ready);
endinterface

// decode to execute unit
interface issue_if;
  import rv_pkg::*;

  logic            valid;
  logic            ready;
  logic [XLEN-1:0] pc;
  logic [ILEN-1:0] inst;
  // decoded operation with operands
  issue_req_t      req;

  modport src (output valid, pc, inst, req, input ready);
  modport dst (input valid, pc, inst, req, output ready);
endinterface

// ==== if_id_regs.sv ====
`timescale 1ns/1ps

module if_id_regs (
  input  logic                     clk,
  input  logic                     i_rst,
  input  logic                     i_valid,
  output logic                     o_ready,
  input  logic [rv_pkg::XLEN-1:0]  i_pc,
  input  logic [rv_pkg::ILEN-1:0]  i_inst,
  fetch_if.src                     out
);
  import rv_pkg::*;

  logic            valid_q;
  logic [XLEN-1:0] pc_q;
  logic [ILEN-1:0] inst_q;

  // allow-in: empty, or the held entry leaves this cycle
  assign o_ready = !valid_q || out.ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      // refill or drain in one step
      valid_q <= i_valid;
    end
  end

  // payload only, no reset needed
  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      pc_q   <= i_pc;
      inst_q <= i_inst;
    end
  end

  assign out.valid = valid_q;
  assign out.pc    = pc_q;
  assign out.inst  = inst_q;

endmodule

// ==== witf.sv ====
`timescale 1ns/1ps

module witf #(
  parameter int WITF_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic [rv_pkg::REG_AW-1:0] i_rs1,
  input  logic [rv_pkg::REG_AW-1:0] i_rs2,
  input  logic                      i_push,
  input  logic [rv_pkg::REG_AW-1:0] i_push_rd,
  input  logic                      i_pop,
  output logic                      o_raw,
  output logic                      o_full
);
  import rv_pkg::*;

  localparam int PW = (WITF_DEPTH > 1) ? $clog2(WITF_DEPTH) : 1;

  logic [REG_AW-1:0]     rd_q [WITF_DEPTH];
  logic [WITF_DEPTH-1:0] vld_q;
  logic [PW-1:0]         wptr_q;
  logic [PW-1:0]         rptr_q;
  logic [PW-1:0]         wptr_nxt;
  logic [PW-1:0]         rptr_nxt;
  logic [WITF_DEPTH-1:0] hit;

  // wrap by hand, depth need not be a power of two
  assign wptr_nxt = (wptr_q == PW'(WITF_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
  assign rptr_nxt = (rptr_q == PW'(WITF_DEPTH - 1)) ? '0 : rptr_q + 1'b1;

  // compare every live entry, x0 never hazards
  always_comb begin
    for (int i = 0; i < WITF_DEPTH; i++) begin
      hit[i] = vld_q[i] &&
               (((i_rs1 != '0) && (rd_q[i] == i_rs1)) ||
                ((i_rs2 != '0) && (rd_q[i] == i_rs2)));
    end
  end

  assign o_raw  = |hit;
  assign o_full = &vld_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      vld_q  <= '0;
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (i_push) begin
        vld_q[wptr_q] <= 1'b1;
        wptr_q        <= wptr_nxt;
      end
      // oldest writer retires first
      if (i_pop) begin
        vld_q[rptr_q] <= 1'b0;
        rptr_q        <= rptr_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      rd_q[wptr_q] <= i_push_rd;
    end
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                      clk,
  input  logic [rv_pkg::REG_AW-1:0] i_raddr1,
  input  logic [rv_pkg::REG_AW-1:0] i_raddr2,
  output logic [rv_pkg::XLEN-1:0]   o_rdata1,
  output logic [rv_pkg::XLEN-1:0]   o_rdata2,
  input  logic                      i_we,
  input  logic [rv_pkg::REG_AW-1:0] i_waddr,
  input  logic [rv_pkg::XLEN-1:0]   i_wdata
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // async reads, x0 forced to zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
  input  logic                      clk,
  input  logic                      i_rst,
  fetch_if.dst                      in,
  issue_if.src                      out,
  output logic [rv_pkg::REG_AW-1:0] o_rs1,
  output logic [rv_pkg::REG_AW-1:0] o_rs2,
  input  logic [rv_pkg::XLEN-1:0]   i_rdata1,
  input  logic [rv_pkg::XLEN-1:0]   i_rdata2,
  input  logic                      i_raw,
  input  logic                      i_full,
  output logic                      o_push,
  output logic [rv_pkg::REG_AW-1:0] o_push_rd
);
  import rv_pkg::*;

  opcode_e           opc;
  logic [2:0]        funct3;
  logic              funct7_5;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_u;
  alu_op_e           alu_op;
  logic [XLEN-1:0]   op_b;
  logic              use_rs1;
  logic              use_rs2;
  logic              known;
  logic              stall;
  logic              fire;

  assign opc      = opcode_e'(in.inst[6:0]);
  assign funct3   = in.inst[14:12];
  // sub vs add, sra vs srl
  assign funct7_5 = in.inst[30];
  assign rd       = in.inst[11:7];
  assign imm_i    = {{(XLEN-12){in.inst[31]}}, in.inst[31:20]};
  assign imm_u    = {{(XLEN-32){in.inst[31]}}, in.inst[31:12], 12'b0};

  always_comb begin
    alu_op  = ALU_ADD;
    op_b    = i_rdata2;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    known   = 1'b0;
    case (opc)
      OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        known   = 1'b1;
        case (funct3)
          3'b000:  alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          // srl only, sra is not supported
          3'b101: begin
            alu_op = ALU_SRL;
            known  = !funct7_5;
          end
          default: known = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        op_b    = imm_i;
        known   = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: known = 1'b0;
        endcase
      end
      OPC_LUI: begin
        op_b   = imm_u;
        alu_op = ALU_PASSB;
        known  = 1'b1;
      end
      // anything else flows through without a write
      default: known = 1'b0;
    endcase
  end

  // unused source fields go to x0 so they never hazard
  assign o_rs1 = use_rs1 ? in.inst[19:15] : '0;
  assign o_rs2 = use_rs2 ? in.inst[24:20] : '0;

  // hold in decode on RAW or no witf slot
  assign stall     = i_raw || i_full;
  assign out.valid = in.valid && !stall;
  assign in.ready  = out.ready && !stall;
  assign fire      = in.valid && !stall && out.ready;

  assign out.pc         = in.pc;
  assign out.inst       = in.inst;
  assign out.req.alu_op = alu_op;
  assign out.req.a      = i_rdata1;
  assign out.req.b      = op_b;
  assign out.req.rd     = rd;
  assign out.req.wen    = known && (rd != '0);

  // record the writer as it leaves decode
  assign o_push    = fire && known && (rd != '0);
  assign o_push_rd = rd;

endmodule

// ==== exu.sv ====
`timescale 1ns/1ps

module exu (
  input  logic                      clk,
  input  logic                      i_rst,
  issue_if.dst                      in,
  output logic                      o_retire_valid,
  input  logic                      i_retire_ready,
  output logic [rv_pkg::ILEN-1:0]   o_retire_inst,
  output logic [rv_pkg::XLEN-1:0]   o_retire_pc,
  output logic [rv_pkg::REG_AW-1:0] o_retire_rd,
  output logic [rv_pkg::XLEN-1:0]   o_retire_wdata,
  output logic                      o_retire_wen
);
  import rv_pkg::*;

  // id/ex stage
  logic              ex_valid;
  logic [XLEN-1:0]   ex_pc;
  logic [ILEN-1:0]   ex_inst;
  issue_req_t        ex_req;
  // ex/wb stage
  logic              wb_valid;
  logic [XLEN-1:0]   wb_pc;
  logic [ILEN-1:0]   wb_inst;
  logic [REG_AW-1:0] wb_rd;
  logic [XLEN-1:0]   wb_wdata;
  logic              wb_wen;

  logic              ex_allow;
  logic              wb_allow;
  logic [5:0]        shamt;
  logic [XLEN-1:0]   alu_res;

  // allow-in chain back from retire
  assign wb_allow = !wb_valid || i_retire_ready;
  assign ex_allow = !ex_valid || wb_allow;
  assign in.ready = ex_allow;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      if (ex_allow) ex_valid <= in.valid;
      if (wb_allow) wb_valid <= ex_valid;
    end
  end

  // rv64 shifts use six bits
  assign shamt = ex_req.b[5:0];

  always_comb begin
    case (ex_req.alu_op)
      ALU_SUB:   alu_res = ex_req.a - ex_req.b;
      ALU_AND:   alu_res = ex_req.a & ex_req.b;
      ALU_OR:    alu_res = ex_req.a | ex_req.b;
      ALU_XOR:   alu_res = ex_req.a ^ ex_req.b;
      ALU_SLL:   alu_res = ex_req.a << shamt;
      ALU_SRL:   alu_res = ex_req.a >> shamt;
      ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(ex_req.a) < $signed(ex_req.b)};
      ALU_PASSB: alu_res = ex_req.b;
      default:   alu_res = ex_req.a + ex_req.b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (in.valid && ex_allow) begin
      ex_pc   <= in.pc;
      ex_inst <= in.inst;
      ex_req  <= in.req;
    end
    // result captured as the id/ex entry moves on
    if (ex_valid && wb_allow) begin
      wb_pc    <= ex_pc;
      wb_inst  <= ex_inst;
      wb_rd    <= ex_req.rd;
      wb_wdata <= alu_res;
      wb_wen   <= ex_req.wen;
    end
  end

  assign o_retire_valid = wb_valid;
  assign o_retire_inst  = wb_inst;
  assign o_retire_pc    = wb_pc;
  assign o_retire_rd    = wb_rd;
  assign o_retire_wdata = wb_wdata;
  assign o_retire_wen   = wb_wen;

endmodule

// ==== core_top.sv ====
`timescale 1ns/1ps

module core_top #(
  parameter int WITF_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      i_rst,
  // instruction input, the fetch side
  input  logic                      i_inst_valid,
  output logic                      o_inst_ready,
  input  logic [rv_pkg::ILEN-1:0]   i_inst,
  input  logic [rv_pkg::XLEN-1:0]   i_pc,
  // retire side
  output logic                      o_retire_valid,
  input  logic                      i_retire_ready,
  output logic [rv_pkg::ILEN-1:0]   o_retire_inst,
  output logic [rv_pkg::XLEN-1:0]   o_retire_pc,
  output logic [rv_pkg::REG_AW-1:0] o_retire_rd,
  output logic [rv_pkg::XLEN-1:0]   o_retire_wdata,
  output logic                      o_retire_wen
);
  import rv_pkg::*;

  fetch_if fetch_bus ();
  issue_if issue_bus ();

  // operand reads, shared with the hazard query
  logic [REG_AW-1:0] id_rs1;
  logic [REG_AW-1:0] id_rs2;
  logic [XLEN-1:0]   id_rdata1;
  logic [XLEN-1:0]   id_rdata2;
  // witf
  logic              is_raw;
  logic              witf_full;
  logic              witf_push;
  logic [REG_AW-1:0] witf_push_rd;
  // writeback on the retire handshake
  logic              retire_we;

  assign retire_we = o_retire_valid && i_retire_ready && o_retire_wen;

  if_id_regs if_id_regs_inst (
    .clk(clk), .i_rst(i_rst),
    .i_valid(i_inst_valid), .o_ready(o_inst_ready),
    .i_pc(i_pc), .i_inst(i_inst),
    .out(fetch_bus)
  );

  inst_decode inst_decode_inst (
    .clk(clk), .i_rst(i_rst),
    .in(fetch_bus), .out(issue_bus),
    .o_rs1(id_rs1), .o_rs2(id_rs2),
    .i_rdata1(id_rdata1), .i_rdata2(id_rdata2),
    .i_raw(is_raw), .i_full(witf_full),
    .o_push(witf_push), .o_push_rd(witf_push_rd)
  );

  witf #(.WITF_DEPTH(WITF_DEPTH)) witf_inst (
    .clk(clk), .i_rst(i_rst),
    .i_rs1(id_rs1), .i_rs2(id_rs2),
    .i_push(witf_push), .i_push_rd(witf_push_rd),
    .i_pop(retire_we),
    .o_raw(is_raw), .o_full(witf_full)
  );

  register_file register_file_inst (
    .clk(clk),
    .i_raddr1(id_rs1), .i_raddr2(id_rs2),
    .o_rdata1(id_rdata1), .o_rdata2(id_rdata2),
    .i_we(retire_we), .i_waddr(o_retire_rd), .i_wdata(o_retire_wdata)
  );

  exu exu_inst (
    .clk(clk), .i_rst(i_rst),
    .in(issue_bus),
    .o_retire_valid(o_retire_valid), .i_retire_ready(i_retire_ready),
    .o_retire_inst(o_retire_inst), .o_retire_pc(o_retire_pc),
    .o_retire_rd(o_retire_rd), .o_retire_wdata(o_retire_wdata),
    .o_retire_wen(o_retire_wen)
  );

endmodule

// ==== core_checker.sv ====
`timescale 1ns/1ps

module core_checker (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_inst_ready,
  input  logic                      i_retire_valid,
  input  logic                      i_retire_ready,
  input  logic [rv_pkg::ILEN-1:0]   i_retire_inst,
  input  logic [rv_pkg::XLEN-1:0]   i_retire_pc,
  input  logic [rv_pkg::REG_AW-1:0] i_retire_rd,
  input  logic [rv_pkg::XLEN-1:0]   i_retire_wdata,
  input  logic                      i_retire_wen,
  // if/id holds an entry
  input  logic                      i_id_valid,
  // id/ex can take an entry
  input  logic                      i_ex_ready
);
  import rv_pkg::*;

  logic [ILEN+XLEN+REG_AW+XLEN:0] payload;
  // number of failed assertions
  int                             fail_count = 0;

  assign payload = {i_retire_inst, i_retire_pc, i_retire_rd, i_retire_wdata, i_retire_wen};

  // reset empties the retire stage
  assert property (@(posedge clk) i_rst |=> !i_retire_valid)
    else begin
      $error("retire valid high after a reset cycle");
      fail_count++;
    end

  // stalled retire keeps its payload
  assert property (@(posedge clk) disable iff (i_rst)
                   (i_retire_valid && !i_retire_ready) |=> (i_retire_valid && $stable(payload)))
    else begin
      $error("retire payload changed while stalled");
      fail_count++;
    end

  // whole pipe full and blocked so the input must close
  assert property (@(posedge clk) disable iff (i_rst)
                   (i_retire_valid && !i_retire_ready && !i_ex_ready && i_id_valid)
                   |-> !i_inst_ready)
    else begin
      $error("input ready high with no room in the pipeline");
      fail_count++;
    end

endmodule

// ==== core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
  import rv_pkg::*;

  localparam int N_ROWS  = 27;
  // first row of the dependent pair timed with retire ready held high
  localparam int PAIR_A  = 25;
  localparam int TCLK    = 20;
  localparam int RST_CYC = 16;
  localparam logic [6:0] F7_0   = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  logic              clk;
  logic              i_rst;
  logic              i_inst_valid;
  logic              o_inst_ready;
  logic [ILEN-1:0]   i_inst;
  logic [XLEN-1:0]   i_pc;
  logic              o_retire_valid;
  logic              i_retire_ready;
  logic [ILEN-1:0]   o_retire_inst;
  logic [XLEN-1:0]   o_retire_pc;
  logic [REG_AW-1:0] o_retire_rd;
  logic [XLEN-1:0]   o_retire_wdata;
  logic              o_retire_wen;

  // program table with one row per instruction
  string             name_tab  [N_ROWS];
  logic [ILEN-1:0]   inst_tab  [N_ROWS];
  logic [XLEN-1:0]   pc_tab    [N_ROWS];
  logic [REG_AW-1:0] rd_tab    [N_ROWS];
  logic              wen_tab   [N_ROWS];
  logic [XLEN-1:0]   wdata_tab [N_ROWS];
  int                retire_cyc [N_ROWS];
  int                n_rows;
  int                retired;
  int                errors;
  logic [31:0]       rng;

  core_top #(.WITF_DEPTH(4)) core_top_inst (
    .clk(clk), .i_rst(i_rst),
    .i_inst_valid(i_inst_valid), .o_inst_ready(o_inst_ready),
    .i_inst(i_inst), .i_pc(i_pc),
    .o_retire_valid(o_retire_valid), .i_retire_ready(i_retire_ready),
    .o_retire_inst(o_retire_inst), .o_retire_pc(o_retire_pc),
    .o_retire_rd(o_retire_rd), .o_retire_wdata(o_retire_wdata),
    .o_retire_wen(o_retire_wen)
  );

  bind core_top core_checker core_checker_inst (
    .clk(clk), .i_rst(i_rst), .i_inst_ready(o_inst_ready),
    .i_retire_valid(o_retire_valid), .i_retire_ready(i_retire_ready),
    .i_retire_inst(o_retire_inst), .i_retire_pc(o_retire_pc),
    .i_retire_rd(o_retire_rd), .i_retire_wdata(o_retire_wdata),
    .i_retire_wen(o_retire_wen),
    .i_id_valid(fetch_bus.valid), .i_ex_ready(issue_bus.ready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // r-type fields from funct7 down to rd
  function automatic logic [ILEN-1:0] enc_r(input logic [6:0] f7, input int rs2,
                                            input int rs1, input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
  endfunction

  function automatic logic [ILEN-1:0] enc_i(input logic [11:0] imm, input int rs1,
                                            input logic [2:0] f3, input int rd);
    return {imm, rs1[4:0], f3, rd[4:0], OPC_OP_IMM};
  endfunction

  function automatic logic [ILEN-1:0] enc_u(input logic [19:0] imm, input int rd);
    return {imm, rd[4:0], OPC_LUI};
  endfunction

  // pc follows the row index in 4 byte steps
  task automatic add_row(input string name, input logic [ILEN-1:0] inst, input int rd,
                         input logic wen, input logic [XLEN-1:0] wdata);
    name_tab[n_rows]  = name;
    inst_tab[n_rows]  = inst;
    pc_tab[n_rows]    = 64'h1000 + 64'(n_rows * 4);
    rd_tab[n_rows]    = rd[4:0];
    wen_tab[n_rows]   = wen;
    wdata_tab[n_rows] = wdata;
    n_rows++;
  endtask

  // expected values worked out by hand from the isa
  // wdata is a don't care when wen is low
  task automatic load_program();
    n_rows = 0;
    add_row("addi_neg", enc_i(12'hffb, 0, 3'b000, 1), 1, 1'b1, 64'hffff_ffff_ffff_fffb);
    add_row("addi_pos", enc_i(12'h00c, 0, 3'b000, 2), 2, 1'b1, 64'hc);
    add_row("andi_neg", enc_i(12'hff0, 1, 3'b111, 3), 3, 1'b1, 64'hffff_ffff_ffff_fff0);
    add_row("ori_neg", enc_i(12'hf00, 2, 3'b110, 4), 4, 1'b1, 64'hffff_ffff_ffff_ff0c);
    add_row("xori_neg", enc_i(12'hfff, 1, 3'b100, 5), 5, 1'b1, 64'h4);
    add_row("lui_neg", enc_u(20'h80000, 6), 6, 1'b1, 64'hffff_ffff_8000_0000);
    add_row("lui_pos", enc_u(20'h12345, 7), 7, 1'b1, 64'h1234_5000);
    add_row("add", enc_r(F7_0, 7, 6, 3'b000, 8), 8, 1'b1, 64'hffff_ffff_9234_5000);
    add_row("sub", enc_r(F7_SUB, 1, 2, 3'b000, 9), 9, 1'b1, 64'h11);
    add_row("and", enc_r(F7_0, 3, 4, 3'b111, 10), 10, 1'b1, 64'hffff_ffff_ffff_ff00);
    add_row("or", enc_r(F7_0, 2, 5, 3'b110, 11), 11, 1'b1, 64'hc);
    add_row("xor", enc_r(F7_0, 1, 6, 3'b100, 12), 12, 1'b1, 64'h7fff_fffb);
    add_row("addi_63", enc_i(12'h03f, 0, 3'b000, 13), 13, 1'b1, 64'h3f);
    // shift amount comes through rs2 from the row directly ahead
    add_row("sll_63", enc_r(F7_0, 13, 1, 3'b001, 14), 14, 1'b1, 64'h8000_0000_0000_0000);
    add_row("srl_63", enc_r(F7_0, 13, 1, 3'b101, 15), 15, 1'b1, 64'h1);
    add_row("slt_neg_pos", enc_r(F7_0, 2, 1, 3'b010, 16), 16, 1'b1, 64'h1);
    add_row("slt_pos_neg", enc_r(F7_0, 1, 2, 3'b010, 17), 17, 1'b1, 64'h0);
    add_row("slt_neg_neg", enc_r(F7_0, 1, 3, 3'b010, 18), 18, 1'b1, 64'h1);
    add_row("addi_base", enc_i(12'h001, 2, 3'b000, 19), 19, 1'b1, 64'hd);
    add_row("addi_rs1_dep", enc_i(12'h001, 19, 3'b000, 19), 19, 1'b1, 64'he);
    add_row("add_rs2_dep", enc_r(F7_0, 19, 2, 3'b000, 20), 20, 1'b1, 64'h1a);
    add_row("addi_x0", enc_i(12'h007, 1, 3'b000, 0), 0, 1'b0, 64'h0);
    add_row("add_x0_x0", enc_r(F7_0, 0, 0, 3'b000, 21), 21, 1'b1, 64'h0);
    // custom-0 opcode with rd x5
    add_row("unknown_op", {20'h0, 5'd5, 7'b0001011}, 5, 1'b0, 64'h0);
    add_row("or_x5_kept", enc_r(F7_0, 0, 5, 3'b110, 22), 22, 1'b1, 64'h4);
    add_row("pair_first", enc_i(12'hffe, 2, 3'b000, 23), 23, 1'b1, 64'ha);
    add_row("pair_second", enc_r(F7_SUB, 2, 23, 3'b000, 24), 24, 1'b1, 64'hffff_ffff_ffff_fffe);
  endtask

  // acts as the fetch unit and drives 2 ns past the edge
  task automatic feed_program();
    int gap;
    for (int i = 0; i < N_ROWS; i++) begin
      if (i == PAIR_A) begin
        // drain everything so the pair starts on an empty pipeline
        i_inst_valid = 1'b0;
        while (retired != PAIR_A) begin
          @(posedge clk);
          #2;
        end
      end else if (i < PAIR_A) begin
        rng = xorshift32(rng);
        gap = int'(rng[1:0]);
        i_inst_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
      end
      i_inst_valid = 1'b1;
      i_inst       = inst_tab[i];
      i_pc         = pc_tab[i];
      // accepted on the edge after a negedge with ready high
      @(negedge clk);
      while (!o_inst_ready) @(negedge clk);
      @(posedge clk);
      #2;
    end
    i_inst_valid = 1'b0;
  endtask

  task automatic check_retire(input int idx);
    int bad;
    bad = 0;
    if (o_retire_inst !== inst_tab[idx]) begin
      $display("ERROR %s inst: expected %h actual %h", name_tab[idx], inst_tab[idx],
               o_retire_inst);
      bad++;
    end
    if (o_retire_pc !== pc_tab[idx]) begin
      $display("ERROR %s pc: expected %h actual %h", name_tab[idx], pc_tab[idx], o_retire_pc);
      bad++;
    end
    if (o_retire_rd !== rd_tab[idx]) begin
      $display("ERROR %s rd: expected %0d actual %0d", name_tab[idx], rd_tab[idx], o_retire_rd);
      bad++;
    end
    if (o_retire_wen !== wen_tab[idx]) begin
      $display("ERROR %s wen: expected %b actual %b", name_tab[idx], wen_tab[idx],
               o_retire_wen);
      bad++;
    end
    if (wen_tab[idx] && (o_retire_wdata !== wdata_tab[idx])) begin
      $display("ERROR %s wdata: expected %h actual %h", name_tab[idx], wdata_tab[idx],
               o_retire_wdata);
      bad++;
    end
    errors += bad;
    $display("%s: %s", name_tab[idx], (bad == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    clk = 1'b0;
    forever #(TCLK / 2) clk = ~clk;
  end

  // retire side drives ready after the edge and samples the handshake at negedge
  initial begin : retire_loop
    int   cyc;
    logic rdy_next;
    cyc      = 0;
    rdy_next = 1'b1;
    @(negedge i_rst);
    forever begin
      @(posedge clk);
      #2;
      i_retire_ready = (retired >= PAIR_A) ? 1'b1 : rdy_next;
      @(negedge clk);
      cyc++;
      if (o_retire_valid && i_retire_ready) begin
        if (retired >= N_ROWS) begin
          $display("an instruction retired after the last program row");
          errors++;
        end else begin
          check_retire(retired);
          retire_cyc[retired] = cyc;
        end
        retired++;
      end
      // ready about three cycles in four
      rng      = xorshift32(rng);
      rdy_next = (rng[1:0] != 2'b00);
    end
  end

  initial begin : watchdog
    #((N_ROWS * 40 + RST_CYC) * TCLK);
    $display("timeout: not every instruction retired, the pipeline seems stuck");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    int spacing;
    i_rst          = 1'b1;
    i_inst_valid   = 1'b0;
    i_inst         = '0;
    i_pc           = '0;
    i_retire_ready = 1'b0;
    rng            = 32'h50ad_1fb1;
    retired        = 0;
    errors         = 0;
    load_program();
    repeat (RST_CYC) @(posedge clk);
    #2;
    i_rst = 1'b0;
    fork
      feed_program();
    join_none
    while (retired < N_ROWS) @(posedge clk);
    // room for a duplicate to show up
    repeat (10) @(posedge clk);
    spacing = retire_cyc[PAIR_A + 1] - retire_cyc[PAIR_A];
    if (spacing != 3) begin
      $display("ERROR pair_spacing: expected 3 actual %0d", spacing);
      errors++;
    end
    $display("pair_spacing: %s", (spacing == 3) ? "ok" : "mismatch");
    if (core_top_inst.core_checker_inst.fail_count != 0) begin
      $display("the bound checker saw %0d failed assertions",
               core_top_inst.core_checker_inst.fail_count);
      errors += core_top_inst.core_checker_inst.fail_count;
    end
    $display("rows %0d, retired %0d, errors %0d", N_ROWS, retired, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rv_pkg.sv
pipe_ifs.sv
if_id_regs.sv
witf.sv
register_file.sv
inst_decode.sv
exu.sv
core_top.sv
core_checker.sv
core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
